// File: include/core_complex_params.svh
`ifndef CORE_COMPLEX_PARAMS_SVH
`define CORE_COMPLEX_PARAMS_SVH

// global x coordinate is {pod field, subcoordinate}
`define CC_X_SUBCORD_WIDTH 2
`define CC_POD_X_CORD_WIDTH 2
`define CC_X_CORD_WIDTH (`CC_POD_X_CORD_WIDTH + `CC_X_SUBCORD_WIDTH)

// tiles in the row, one per subcoordinate
`define CC_NUM_TILES 4

// pod 0 is the west io column, the row sits in pod 1
`define CC_POD_X 1

// word index inside one tile
`define CC_ADDR_WIDTH 4

`define CC_DATA_WIDTH 32

// destination register tag of a load
`define CC_REG_ID_WIDTH 5

// forward fifo depth, equals the host credit count
`define CC_FWD_CREDITS 4

// reverse link credits after reset
`define CC_REV_CREDITS 2

`define CC_REV_FIFO_DEPTH 4

`endif

// File: source/core_complex_pkg.sv
`include "core_complex_params.svh"

package core_complex_pkg;

  typedef enum logic [0:0]
  {
    e_op_store = 1'b0
    ,e_op_load = 1'b1
  } cc_op_e;

  typedef enum logic [0:0]
  {
    e_return_credit = 1'b0
    ,e_return_data  = 1'b1
  } cc_rev_type_e;

  // load info shares the payload word with store data
  typedef struct packed
  {
    logic [`CC_DATA_WIDTH-`CC_REG_ID_WIDTH-1:0] reserved;
    logic [`CC_REG_ID_WIDTH-1:0]                reg_id;
  } cc_load_info_s;

  typedef union packed
  {
    logic [`CC_DATA_WIDTH-1:0] data;
    cc_load_info_s             load_info;
  } cc_payload_u;

  typedef struct packed
  {
    cc_op_e                      op;
    logic [`CC_X_CORD_WIDTH-1:0] x_cord;
    logic [`CC_ADDR_WIDTH-1:0]   addr;
    logic [`CC_X_CORD_WIDTH-1:0] src_x_cord;
    cc_payload_u                 payload;
  } cc_fwd_packet_s;

  typedef struct packed
  {
    cc_rev_type_e                return_type;
    logic [`CC_REG_ID_WIDTH-1:0] reg_id;
    logic [`CC_X_CORD_WIDTH-1:0] src_x_cord;
    logic [`CC_DATA_WIDTH-1:0]   data;
  } cc_rev_packet_s;

endpackage

// File: source/sdr_link_rx.sv
`timescale 1ns/10ps

`include "core_complex_params.svh"

module sdr_link_rx
  (input                                    clk_i
  ,input                                    reset_i

  ,input                                    fwd_v_i
  ,input  core_complex_pkg::cc_fwd_packet_s fwd_data_i
  ,output logic                             fwd_token_o

  ,output logic                             req_v_o
  ,output core_complex_pkg::cc_fwd_packet_s req_packet_o
  ,input                                    req_yumi_i
  );

  localparam ptr_width_lp = $clog2(`CC_FWD_CREDITS);

  core_complex_pkg::cc_fwd_packet_s fifo_r [`CC_FWD_CREDITS];

  // extra wrap bit tells full from empty
  logic [ptr_width_lp:0] wptr_r;
  logic [ptr_width_lp:0] rptr_r;

  assign req_v_o      = (wptr_r != rptr_r);
  assign req_packet_o = fifo_r[rptr_r[ptr_width_lp-1:0]];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
    end
    else
    begin
      // the host sends only while it holds a credit
      if (fwd_v_i)
        wptr_r <= wptr_r + 1'b1;
      if (req_yumi_i)
        rptr_r <= rptr_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_v_i)
      fifo_r[wptr_r[ptr_width_lp-1:0]] <= fwd_data_i;
  end

  // one token per consumed flit, a cycle after the take
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      fwd_token_o <= 1'b0;
    else
      fwd_token_o <= req_yumi_i;
  end

endmodule

// File: source/pod_row_tiles.sv
`timescale 1ns/10ps

`include "core_complex_params.svh"

module pod_row_tiles
  (input                                    clk_i
  ,input                                    reset_i

  ,input                                    req_v_i
  ,input  core_complex_pkg::cc_fwd_packet_s req_packet_i
  ,output logic                             req_yumi_o

  ,output logic                             ret_v_o
  ,output core_complex_pkg::cc_rev_packet_s ret_packet_o
  ,input                                    ret_full_i
  );

  localparam words_lp = 1 << `CC_ADDR_WIDTH;
  localparam logic [`CC_POD_X_CORD_WIDTH-1:0] pod_x_lp = `CC_POD_X_CORD_WIDTH'(`CC_POD_X);

  logic [`CC_POD_X_CORD_WIDTH-1:0] pod_cord;
  logic [`CC_X_SUBCORD_WIDTH-1:0]  tile_id;
  logic                            pod_hit;
  logic                            take;
  logic                            take_store;
  logic                            take_load;

  logic [`CC_X_CORD_WIDTH-1:0] tile_x_cord [`CC_NUM_TILES];

  logic [`CC_DATA_WIDTH-1:0] mem_r [`CC_NUM_TILES][words_lp];

  // global x of each tile in the row
  for (genvar i = 0; i < `CC_NUM_TILES; i++)
  begin: cord
    assign tile_x_cord[i] = {pod_x_lp, `CC_X_SUBCORD_WIDTH'(i)};
  end

  assign pod_cord = req_packet_i.x_cord[`CC_X_CORD_WIDTH-1-:`CC_POD_X_CORD_WIDTH];
  assign tile_id  = req_packet_i.x_cord[`CC_X_SUBCORD_WIDTH-1:0];
  assign pod_hit  = (pod_cord == pod_x_lp);

  // packets for another pod are still taken, then dropped
  assign req_yumi_o = req_v_i & ~ret_full_i;
  assign take       = req_yumi_o & pod_hit;
  assign take_store = take & (req_packet_i.op == core_complex_pkg::e_op_store);
  assign take_load  = take & (req_packet_i.op == core_complex_pkg::e_op_load);

  always_ff @(posedge clk_i)
  begin
    if (take_store)
      mem_r[tile_id][req_packet_i.addr] <= req_packet_i.payload.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      ret_v_o <= 1'b0;
    else
      ret_v_o <= take;
  end

  always_ff @(posedge clk_i)
  begin
    if (take_store)
    begin
      ret_packet_o.return_type <= core_complex_pkg::e_return_credit;
      ret_packet_o.reg_id      <= '0;
      ret_packet_o.src_x_cord  <= tile_x_cord[tile_id];
      ret_packet_o.data        <= '0;
    end
    else if (take_load)
    begin
      // same payload word, read as load info
      ret_packet_o.return_type <= core_complex_pkg::e_return_data;
      ret_packet_o.reg_id      <= req_packet_i.payload.load_info.reg_id;
      ret_packet_o.src_x_cord  <= tile_x_cord[tile_id];
      ret_packet_o.data        <= mem_r[tile_id][req_packet_i.addr];
    end
  end

endmodule

// File: source/sdr_link_tx.sv
`timescale 1ns/10ps

`include "core_complex_params.svh"

module sdr_link_tx
  (input                                    clk_i
  ,input                                    reset_i

  ,input                                    ret_v_i
  ,input  core_complex_pkg::cc_rev_packet_s ret_packet_i
  ,output logic                             ret_full_o

  ,output logic                             rev_v_o
  ,output core_complex_pkg::cc_rev_packet_s rev_data_o
  ,input                                    rev_token_i
  );

  localparam ptr_width_lp    = $clog2(`CC_REV_FIFO_DEPTH);
  localparam count_width_lp  = $clog2(`CC_REV_FIFO_DEPTH + 1);
  localparam credit_width_lp = $clog2(`CC_REV_CREDITS + 1);

  core_complex_pkg::cc_rev_packet_s queue_r [`CC_REV_FIFO_DEPTH];

  logic [ptr_width_lp-1:0]    wptr_r;
  logic [ptr_width_lp-1:0]    rptr_r;
  logic [count_width_lp-1:0]  count_r;
  logic [credit_width_lp-1:0] credit_r;
  logic                       send;

  assign send = (count_r != '0) && (credit_r != '0);

  // leave room for the return the tiles already have in flight
  assign ret_full_o = (count_r + count_width_lp'(ret_v_i))
                      >= count_width_lp'(`CC_REV_FIFO_DEPTH);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r   <= '0;
      rptr_r   <= '0;
      count_r  <= '0;
      credit_r <= credit_width_lp'(`CC_REV_CREDITS);
      rev_v_o  <= 1'b0;
    end
    else
    begin
      if (ret_v_i)
        wptr_r <= wptr_r + 1'b1;
      if (send)
        rptr_r <= rptr_r + 1'b1;
      count_r  <= count_r + count_width_lp'(ret_v_i) - count_width_lp'(send);
      // spend one credit per flit, regain one per token
      credit_r <= credit_r + credit_width_lp'(rev_token_i) - credit_width_lp'(send);
      rev_v_o  <= send;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (ret_v_i)
      queue_r[wptr_r] <= ret_packet_i;
    if (send)
      rev_data_o <= queue_r[rptr_r];
  end

endmodule

// File: source/core_complex.sv
`timescale 1ns/10ps

module core_complex
  (input                                    clk_i
  ,input                                    reset_i

  ,input                                    fwd_v_i
  ,input  core_complex_pkg::cc_fwd_packet_s fwd_data_i
  ,output logic                             fwd_token_o

  ,output logic                             rev_v_o
  ,output core_complex_pkg::cc_rev_packet_s rev_data_o
  ,input                                    rev_token_i
  );

  logic                             req_v;
  logic                             req_yumi;
  core_complex_pkg::cc_fwd_packet_s req_packet;

  logic                             ret_v;
  logic                             ret_full;
  core_complex_pkg::cc_rev_packet_s ret_packet;

  sdr_link_rx rx
    (.clk_i       (clk_i      )
    ,.reset_i     (reset_i    )
    ,.fwd_v_i     (fwd_v_i    )
    ,.fwd_data_i  (fwd_data_i )
    ,.fwd_token_o (fwd_token_o)
    ,.req_v_o     (req_v      )
    ,.req_packet_o(req_packet )
    ,.req_yumi_i  (req_yumi   )
    );

  pod_row_tiles tiles
    (.clk_i       (clk_i     )
    ,.reset_i     (reset_i   )
    ,.req_v_i     (req_v     )
    ,.req_packet_i(req_packet)
    ,.req_yumi_o  (req_yumi  )
    ,.ret_v_o     (ret_v     )
    ,.ret_packet_o(ret_packet)
    ,.ret_full_i  (ret_full  )
    );

  sdr_link_tx tx
    (.clk_i       (clk_i      )
    ,.reset_i     (reset_i    )
    ,.ret_v_i     (ret_v      )
    ,.ret_packet_i(ret_packet )
    ,.ret_full_o  (ret_full   )
    ,.rev_v_o     (rev_v_o    )
    ,.rev_data_o  (rev_data_o )
    ,.rev_token_i (rev_token_i)
    );

endmodule

// File: bench/core_complex_tb.sv
`timescale 1ns/10ps

`include "core_complex_params.svh"

module core_complex_tb;

  localparam int timeout_lp = 200;
  localparam int words_lp   = 1 << `CC_ADDR_WIDTH;

  logic                             clk_i;
  logic                             reset_i;
  logic                             fwd_v_i;
  core_complex_pkg::cc_fwd_packet_s fwd_data_i;
  logic                             fwd_token_o;
  logic                             rev_v_o;
  core_complex_pkg::cc_rev_packet_s rev_data_o;
  logic                             rev_token_i;

  // stimulus table, one row per flit
  string                            tbl_name   [$];
  core_complex_pkg::cc_fwd_packet_s tbl_packet [$];
  bit                               tbl_expect [$];
  core_complex_pkg::cc_rev_packet_s tbl_return [$];
  bit                               tbl_hold   [$];

  // expected returns in send order
  string                            sb_name   [$];
  core_complex_pkg::cc_rev_packet_s sb_packet [$];

  logic [`CC_DATA_WIDTH-1:0] model_mem [`CC_NUM_TILES][words_lp];
  logic [31:0]               lcg_state;

  int sent_count;
  int hold_base;
  bit hold_r;
  int rev_count;
  int token_count;
  int owed_tokens;
  bit token_req;

  core_complex dut
    (.clk_i      (clk_i      )
    ,.reset_i    (reset_i    )
    ,.fwd_v_i    (fwd_v_i    )
    ,.fwd_data_i (fwd_data_i )
    ,.fwd_token_o(fwd_token_o)
    ,.rev_v_o    (rev_v_o    )
    ,.rev_data_o (rev_data_o )
    ,.rev_token_i(rev_token_i)
    );

  initial
  begin
    clk_i = 1'b0;
    forever
      #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [`CC_X_CORD_WIDTH-1:0] make_cord(input int pod, input int tile);
    logic [`CC_POD_X_CORD_WIDTH-1:0] pod_f;
    logic [`CC_X_SUBCORD_WIDTH-1:0]  tile_f;
    pod_f  = pod[`CC_POD_X_CORD_WIDTH-1:0];
    tile_f = tile[`CC_X_SUBCORD_WIDTH-1:0];
    return {pod_f, tile_f};
  endfunction

  // host credits left, refilled by forward tokens
  function automatic int free_credits();
    return `CC_FWD_CREDITS - sent_count + token_count;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("FAIL %s expected %h actual %h", name, expected, actual);
    $display("Checks failed");
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
  endtask

  task automatic add_entry(input string name, input core_complex_pkg::cc_fwd_packet_s pkt,
                           input bit expect_return, input core_complex_pkg::cc_rev_packet_s ret,
                           input bit hold);
    tbl_name.push_back(name);
    tbl_packet.push_back(pkt);
    tbl_expect.push_back(expect_return);
    tbl_return.push_back(ret);
    tbl_hold.push_back(hold);
  endtask

  task automatic add_store(input string name, input int pod, input int tile, input int addr,
                           input bit hold);
    core_complex_pkg::cc_fwd_packet_s pkt;
    core_complex_pkg::cc_rev_packet_s ret;
    logic [`CC_X_SUBCORD_WIDTH-1:0]   tile_f;
    logic [`CC_ADDR_WIDTH-1:0]        addr_f;
    bit                               hit;
    lcg_state = lcg_next(lcg_state);
    tile_f    = tile[`CC_X_SUBCORD_WIDTH-1:0];
    addr_f    = addr[`CC_ADDR_WIDTH-1:0];
    hit       = (pod == `CC_POD_X);
    pkt              = '0;
    pkt.op           = core_complex_pkg::e_op_store;
    pkt.x_cord       = make_cord(pod, tile);
    pkt.addr         = addr_f;
    pkt.payload.data = lcg_state;
    // store ack carries no data
    ret             = '0;
    ret.return_type = core_complex_pkg::e_return_credit;
    ret.src_x_cord  = make_cord(`CC_POD_X, tile);
    if (hit)
      model_mem[tile_f][addr_f] = lcg_state;
    add_entry(name, pkt, hit, ret, hold);
  endtask

  task automatic add_load(input string name, input int pod, input int tile, input int addr,
                          input int reg_id, input bit hold);
    core_complex_pkg::cc_fwd_packet_s pkt;
    core_complex_pkg::cc_rev_packet_s ret;
    logic [`CC_X_SUBCORD_WIDTH-1:0]   tile_f;
    logic [`CC_ADDR_WIDTH-1:0]        addr_f;
    tile_f = tile[`CC_X_SUBCORD_WIDTH-1:0];
    addr_f = addr[`CC_ADDR_WIDTH-1:0];
    pkt                           = '0;
    pkt.op                        = core_complex_pkg::e_op_load;
    pkt.x_cord                    = make_cord(pod, tile);
    pkt.addr                      = addr_f;
    pkt.payload.load_info.reg_id  = reg_id[`CC_REG_ID_WIDTH-1:0];
    ret             = '0;
    ret.return_type = core_complex_pkg::e_return_data;
    ret.reg_id      = reg_id[`CC_REG_ID_WIDTH-1:0];
    ret.src_x_cord  = make_cord(`CC_POD_X, tile);
    ret.data        = model_mem[tile_f][addr_f];
    add_entry(name, pkt, (pod == `CC_POD_X), ret, hold);
  endtask

  task automatic build_table();
    // same address in every tile
    for (int t = 0; t < `CC_NUM_TILES; t++)
      add_store($sformatf("store_tile%0d", t), `CC_POD_X, t, 5, 1'b0);
    for (int t = 0; t < `CC_NUM_TILES; t++)
      add_load($sformatf("load_tile%0d", t), `CC_POD_X, t, 5, t + 3, 1'b0);
    add_store("store_low", `CC_POD_X, 2, 0, 1'b0);
    add_store("store_high", `CC_POD_X, 2, 15, 1'b0);
    add_load("load_high", `CC_POD_X, 2, 15, 17, 1'b0);
    add_load("load_low", `CC_POD_X, 2, 0, 30, 1'b0);
    // other pods are dropped, west io column included
    add_store("foreign_west", 0, 1, 5, 1'b0);
    add_store("foreign_pod2", 2, 3, 5, 1'b0);
    add_load("foreign_pod3", 3, 0, 5, 9, 1'b0);
    add_load("after_west", `CC_POD_X, 1, 5, 1, 1'b0);
    add_load("after_pod2", `CC_POD_X, 3, 5, 2, 1'b0);
    // reverse tokens withheld for this run of rows
    add_store("hold_store0", `CC_POD_X, 0, 1, 1'b1);
    add_store("hold_store1", `CC_POD_X, 1, 1, 1'b1);
    add_load("hold_load0", `CC_POD_X, 0, 1, 4, 1'b1);
    add_load("hold_load1", `CC_POD_X, 1, 1, 5, 1'b1);
    add_store("hold_store2", `CC_POD_X, 2, 7, 1'b1);
    add_load("hold_load2", `CC_POD_X, 2, 7, 6, 1'b1);
    add_load("hold_load3", `CC_POD_X, 3, 5, 7, 1'b1);
    add_load("hold_load4", `CC_POD_X, 0, 5, 8, 1'b1);
    add_load("resume_load1", `CC_POD_X, 1, 1, 10, 1'b0);
    add_load("resume_load2", `CC_POD_X, 2, 0, 11, 1'b0);
  endtask

  task automatic send_flit(input int idx);
    int waited;
    waited = 0;
    while (free_credits() == 0)
    begin
      fwd_v_i <= 1'b0;
      @(posedge clk_i);
      waited++;
      assert (waited < timeout_lp)
      else
      begin
        report_error("timed out waiting for a forward link token");
        $fatal(1);
      end
    end
    fwd_v_i    <= 1'b1;
    fwd_data_i <= tbl_packet[idx];
    sent_count++;
    if (tbl_expect[idx])
    begin
      sb_name.push_back(tbl_name[idx]);
      sb_packet.push_back(tbl_return[idx]);
    end
    @(posedge clk_i);
  endtask

  task automatic drain_returns(input string what);
    int waited;
    waited = 0;
    fwd_v_i <= 1'b0;
    while (rev_count != sb_packet.size() || owed_tokens != 0 || token_req
           || free_credits() < `CC_FWD_CREDITS)
    begin
      @(posedge clk_i);
      waited++;
      assert (waited < timeout_lp)
      else
      begin
        report_error({"timed out waiting for ", what});
        $fatal(1);
      end
    end
    @(posedge clk_i);
    // one token per flit, dropped packets included
    assert (token_count == sent_count)
    else
    begin
      report_mismatch("token_total", 64'(sent_count), 64'(token_count));
      $fatal(1);
    end
  endtask

  task automatic start_hold();
    drain_returns("the link to go idle before withholding reverse tokens");
    hold_base = rev_count;
    hold_r   <= 1'b1;
  endtask

  task automatic end_hold();
    int waited;
    waited = 0;
    fwd_v_i <= 1'b0;
    while (rev_count - hold_base < `CC_REV_CREDITS)
    begin
      @(posedge clk_i);
      waited++;
      assert (waited < timeout_lp)
      else
      begin
        report_error("timed out waiting for the returns that the reverse credits allow");
        $fatal(1);
      end
    end
    // credits are spent, so the link has to stay quiet
    repeat (30) @(posedge clk_i);
    assert (rev_count - hold_base <= `CC_REV_CREDITS)
    else
    begin
      report_mismatch("hold_tokens", 64'(`CC_REV_CREDITS), 64'(rev_count - hold_base));
      $fatal(1);
    end
    hold_r <= 1'b0;
  endtask

  // reverse link monitor and scoreboard
  initial
  begin
    core_complex_pkg::cc_rev_packet_s expected;
    rev_count   = 0;
    token_count = 0;
    owed_tokens = 0;
    token_req   = 1'b0;
    forever
    begin
      @(negedge clk_i);
      if (!reset_i && rev_v_o)
      begin
        assert (rev_count < sb_packet.size())
        else
        begin
          report_error("a return packet arrived when none was expected");
          $fatal(1);
        end
        expected = sb_packet[rev_count];
        assert (rev_data_o == expected)
        else
        begin
          report_mismatch(sb_name[rev_count], 64'(expected), 64'(rev_data_o));
          $fatal(1);
        end
        rev_count   = rev_count + 1;
        owed_tokens = owed_tokens + 1;
      end
      if (!reset_i && fwd_token_o)
        token_count = token_count + 1;
      // at most one reverse token per cycle
      token_req = !hold_r && (owed_tokens > 0);
      if (token_req)
        owed_tokens = owed_tokens - 1;
    end
  end

  initial
  begin
    rev_token_i = 1'b0;
    forever
    begin
      @(posedge clk_i);
      rev_token_i <= token_req;
    end
  end

  initial
  begin
    reset_i    = 1'b1;
    fwd_v_i    = 1'b0;
    fwd_data_i = '0;
    hold_r     = 1'b0;
    sent_count = 0;
    hold_base  = 0;
    lcg_state  = 32'hceb0;
    build_table();
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    for (int i = 0; i < tbl_name.size(); i++)
    begin
      if (tbl_hold[i] && !hold_r)
        start_hold();
      else if (!tbl_hold[i] && hold_r)
        end_hold();
      send_flit(i);
    end
    fwd_v_i <= 1'b0;
    if (hold_r)
      end_hold();
    drain_returns("the last returns and forward tokens");
    $display("All checks passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
source/core_complex_pkg.sv
source/sdr_link_rx.sv
source/pod_row_tiles.sv
source/sdr_link_tx.sv
source/core_complex.sv
bench/core_complex_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the core_complex testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module core_complex_tb \
  -o sim_core_complex
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_core_complex 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "All checks passed"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
